// File: bench/spi_slave_model.sv
// display spi port model
// records every write seen while sen is low
// answers with a zero high byte, then the inverted address byte
`timescale 1ns/1ps

module spi_slave_model (
  input  logic        spi_sen_i,
  input  logic        spi_sck_i,
  input  logic        spi_mosi_i,
  output logic        spi_miso_o,
  output logic [15:0] frame_o,
  output int          frame_bits_o,
  output int          frame_cnt_o
);

  logic [15:0] shift_in;
  logic [7:0]  reply_sh;
  int          bits;

  initial begin
    spi_miso_o   = 1'b0;
    frame_o      = '0;
    frame_bits_o = 0;
    frame_cnt_o  = 0;
    shift_in     = '0;
    reply_sh     = '0;
    bits         = 0;
    forever begin
      @(negedge spi_sen_i);
      // high byte of the answer is all zero
      spi_miso_o = 1'b0;
      shift_in   = '0;
      bits       = 0;
      while (!spi_sen_i) begin
        @(spi_sck_i or spi_sen_i);
        if (!spi_sen_i && spi_sck_i) begin
          // mode 0, mosi taken on the rising edge
          shift_in = {shift_in[14:0], spi_mosi_i};
          bits     = bits + 1;
          // address byte complete
          if (bits == 8) begin
            reply_sh = ~shift_in[7:0];
          end
        end else if (!spi_sen_i && bits >= 8 && bits < 16) begin
          // next answer bit ahead of the next rising edge
          spi_miso_o = reply_sh[7];
          reply_sh   = {reply_sh[6:0], 1'b0};
        end
      end
      // sen back high, publish the write
      frame_o      = shift_in;
      frame_bits_o = bits;
      frame_cnt_o  = frame_cnt_o + 1;
    end
  end

endmodule

// File: bench/tb_slm_ctrl.sv
// testbench for the display command path
// sends address/data pairs over uart, checks every spi write
// and every reply byte against queues of expected values
`timescale 1ns/1ps
`include "slm_cfg.svh"

module tb_slm_ctrl;

  localparam int CLK_PERIOD_NS = 8;
  localparam int BIT_CLKS = `SLM_CLKS_PER_BIT;
  localparam int RESET_CYCLES = 5;
  localparam int DIRECTED_PAIRS = 4;
  localparam int RANDOM_PAIRS = 40;
  // directed pairs, one lone byte, random pairs
  localparam int BYTES_SENT = 2 * DIRECTED_PAIRS + 1 + 2 * RANDOM_PAIRS;
  localparam longint FRAME_NS = 10 * BIT_CLKS * CLK_PERIOD_NS;
  localparam longint WATCHDOG_NS = BYTES_SENT * 30 * FRAME_NS;
  localparam logic [31:0] RAND_SEED = 32'h26183122;

  logic        fpga_clk = 1'b0;
  logic        reset_all_cmd_w;
  logic        uart_rx_i;
  logic        uart_tx_o;
  logic        spi_sen_o;
  logic        spi_sck_o;
  logic        spi_mosi_o;
  logic        spi_miso_i;
  logic        slm_reset_n_o;
  logic        slm_clk_o;
  logic [15:0] seen_frame;
  int          seen_bits;
  int          frame_cnt;
  int          frames_checked = 0;

  // reference model filled as each pair is sent
  logic [15:0] exp_frames [$];
  logic [7:0]  exp_replies [$];

  always #(CLK_PERIOD_NS / 2) fpga_clk = ~fpga_clk;

  slm_ctrl_top UUT (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .uart_tx_o       (uart_tx_o),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_mosi_o      (spi_mosi_o),
    .spi_miso_i      (spi_miso_i),
    .slm_reset_n_o   (slm_reset_n_o),
    .slm_clk_o       (slm_clk_o)
  );

  spi_slave_model u_spi_slave (
    .spi_sen_i    (spi_sen_o),
    .spi_sck_i    (spi_sck_o),
    .spi_mosi_i   (spi_mosi_o),
    .spi_miso_o   (spi_miso_i),
    .frame_o      (seen_frame),
    .frame_bits_o (seen_bits),
    .frame_cnt_o  (frame_cnt)
  );

  //////////////////////////////////////////////////
  // failure reporting and checks
  //////////////////////////////////////////////////
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("error at %0t ns: %s is 0x%0h, expected 0x%0h",
                         $time, name, got, expected));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  // reset pulse plus idle and display reset checks
  task automatic apply_reset();
    int cycle;
    int low_cycles;
    reset_all_cmd_w = 1'b1;
    for (cycle = 0; cycle < RESET_CYCLES; cycle++) begin
      @(negedge fpga_clk);
      check_value("spi_sen_o", 32'(spi_sen_o), 32'd1);
      check_value("spi_sck_o", 32'(spi_sck_o), 32'd0);
      check_value("uart_tx_o", 32'(uart_tx_o), 32'd1);
      check_value("slm_reset_n_o", 32'(slm_reset_n_o), 32'd0);
    end
    reset_all_cmd_w = 1'b0;
    low_cycles = 0;
    @(negedge fpga_clk);
    // bounded in case the display reset never releases
    while (slm_reset_n_o == 1'b0 && low_cycles <= `SLM_RESET_HOLD) begin
      low_cycles = low_cycles + 1;
      @(negedge fpga_clk);
    end
    check_value("slm_reset_n_o low cycles", 32'(low_cycles), 32'(`SLM_RESET_HOLD));
    check_value("spi_sen_o", 32'(spi_sen_o), 32'd1);
    check_value("spi_sck_o", 32'(spi_sck_o), 32'd0);
    check_value("uart_tx_o", 32'(uart_tx_o), 32'd1);
  endtask

  // display clock follows the system clock in both phases
  task automatic verify_display_clock();
    @(negedge fpga_clk);
    #(CLK_PERIOD_NS / 4);
    check_value("slm_clk_o", 32'(slm_clk_o), 32'd0);
    @(posedge fpga_clk);
    #(CLK_PERIOD_NS / 4);
    check_value("slm_clk_o", 32'(slm_clk_o), 32'd1);
    @(negedge fpga_clk);
  endtask

  // one uart character driven from falling edge to falling edge
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] line_bits;
    int         i;
    line_bits = {1'b1, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      uart_rx_i = line_bits[i];
      repeat (BIT_CLKS) @(negedge fpga_clk);
    end
  endtask

  task automatic send_pair(input logic [7:0] addr, input logic [7:0] data);
    exp_frames.push_back({addr, data});
    // display answers with the inverted address
    exp_replies.push_back(~addr);
    send_byte(addr);
    send_byte(data);
  endtask

  task automatic wait_for_drain();
    while (exp_frames.size() != 0 || exp_replies.size() != 0) begin
      @(negedge fpga_clk);
    end
  endtask

  //////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////
  // each new write from the slave model is compared in order
  always @(negedge fpga_clk) begin : frame_checker
    if (frame_cnt != frames_checked) begin
      check_value("spi frame bit count", 32'(seen_bits), 32'd16);
      if (exp_frames.size() == 0) begin
        fail_run("an spi write appeared with no byte pair sent");
      end else begin
        check_value("spi_mosi_o frame", 32'(seen_frame), 32'(exp_frames.pop_front()));
      end
      frames_checked = frames_checked + 1;
    end
  end

  // decodes uart_tx_o with mid bit sampling
  always begin : reply_monitor
    logic [7:0] got;
    int         k;
    @(negedge fpga_clk);
    if (!reset_all_cmd_w && uart_tx_o == 1'b0) begin
      got = '0;
      repeat (BIT_CLKS / 2) @(negedge fpga_clk);
      if (uart_tx_o != 1'b0) begin
        fail_run("uart_tx_o start bit did not stay low");
      end else begin
        for (k = 0; k < 8; k++) begin
          repeat (BIT_CLKS) @(negedge fpga_clk);
          got = {uart_tx_o, got[7:1]};
        end
        repeat (BIT_CLKS) @(negedge fpga_clk);
        if (uart_tx_o != 1'b1) begin
          fail_run("uart_tx_o stop bit was low");
        end else if (exp_replies.size() == 0) begin
          fail_run("uart_tx_o sent a reply byte with no write pending");
        end else begin
          check_value("uart_tx_o reply", 32'(got), 32'(exp_replies.pop_front()));
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the test sequence finished");
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin : main_sequence
    logic [7:0] addr;
    logic [7:0] data;
    int         frames_before;
    int         n;
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    void'($urandom(RAND_SEED));
    apply_reset();
    verify_display_clock();

    // directed writes where 0xbc is a plain write
    send_pair(8'h12, 8'h34);
    send_pair(8'hBC, 8'h01);
    send_pair(8'h00, 8'hFF);
    wait_for_drain();

    // lone address byte must not start a write
    frames_before = frame_cnt;
    send_byte(8'h5A);
    repeat (2 * BIT_CLKS) @(negedge fpga_clk);
    check_value("spi frame count", 32'(frame_cnt), 32'(frames_before));
    // pairing restarts so the next byte is an address
    apply_reset();
    send_pair(8'hA5, 8'h3C);

    // back to back random pairs
    for (n = 0; n < RANDOM_PAIRS; n++) begin
      addr = 8'($urandom());
      data = 8'($urandom());
      send_pair(addr, data);
    end
    wait_for_drain();
    // quiet window where any extra reply trips the monitor
    repeat (3 * 10 * BIT_CLKS) @(negedge fpga_clk);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: hdl/cmd_assembler.sv
// host command assembler
// even bytes give the register address, odd bytes the data
// every completed pair launches one spi write
`timescale 1ns/1ps

module cmd_assembler import uart_pkg::*, spi_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       rx_valid_i,
  input  uart_byte_t rx_byte_i,
  spi_req_if.requester spi_req
);

  spi_reg_addr_t addr_q;
  spi_frame_u    frame_q;
  logic          data_phase_q;
  logic          start_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // next byte is an address
      data_phase_q <= 1'b0;
      start_q      <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (rx_valid_i) begin
        if (!data_phase_q) begin
          addr_q       <= spi_reg_addr_t'(rx_byte_i);
          data_phase_q <= 1'b1;
        end else begin
          // address byte leads on the wire
          frame_q.field.addr <= addr_q;
          frame_q.field.data <= rx_byte_i;
          start_q            <= 1'b1;
          data_phase_q       <= 1'b0;
        end
      end
    end
  end

  assign spi_req.start = start_q;
  assign spi_req.frame = frame_q;

endmodule

// File: hdl/reply_queue.sv
// spi reply queue
// circular byte buffer filled on each finished transfer
// drained one byte at a time into the uart transmitter when idle
`timescale 1ns/1ps
`include "slm_cfg.svh"

module reply_queue import uart_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  spi_req_if.collector spi_req,
  input  logic       tx_active_i,
  output logic       tx_start_o,
  output uart_byte_t tx_byte_o
);

  localparam int DEPTH = `SLM_REPLY_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  uart_byte_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop_q;
  logic             push;
  logic             pop;

  // replies past a full queue are lost
  assign push = spi_req.done && (count != CNT_FULL);
  // hold off while the previous pop has not yet raised active
  assign pop = (count != '0) && !tx_active_i && !pop_q && !tx_start_o;

  always_ff @(posedge fpga_clk) begin
    if (push) begin
      mem[wr_ptr] <= spi_req.reply;
    end
    if (pop) begin
      tx_byte_o <= mem[rd_ptr];
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      pop_q      <= 1'b0;
      tx_start_o <= 1'b0;
    end else begin
      // start one cycle after the pop
      pop_q      <= pop;
      tx_start_o <= pop_q;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

// File: hdl/slm_cfg.svh
// display command path build constants
// uart bit timing, spi clock divider, display reset stretch
// and reply queue size
`ifndef SLM_CFG_SVH
`define SLM_CFG_SVH

//////////////////////////////////////////////////
// uart
//////////////////////////////////////////////////
// 62.5 MHz / 1 Mbaud, rounded down
`define SLM_CLKS_PER_BIT 62

//////////////////////////////////////////////////
// display spi and reset
//////////////////////////////////////////////////
// clocks per sck half period
`define SLM_SPI_HALF_PERIOD 4
// display reset low time once the command drops
`define SLM_RESET_HOLD 10

// replies buffered toward the host
`define SLM_REPLY_DEPTH 4

`endif

// File: hdl/slm_ctrl_top.sv
// display controller command path top level
// host uart bytes become spi register writes, spi replies
// go back on uart, display reset and clock come from here
`timescale 1ns/1ps
`include "slm_cfg.svh"

module slm_ctrl_top import uart_pkg::*; (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_mosi_o,
  input  logic spi_miso_i,
  output logic slm_reset_n_o,
  output logic slm_clk_o
);

  logic       rx_valid;
  uart_byte_t rx_byte;
  logic       tx_start;
  uart_byte_t tx_byte;
  logic       tx_active;

  spi_req_if spi_req ();

  //////////////////////////////////////////////////
  // host uart
  //////////////////////////////////////////////////
  uart_rx #(.CLKS_PER_BIT(`SLM_CLKS_PER_BIT)) u_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  uart_tx #(.CLKS_PER_BIT(`SLM_CLKS_PER_BIT)) u_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .tx_active_o     (tx_active),
    .tx_serial_o     (uart_tx_o)
  );

  //////////////////////////////////////////////////
  // command and reply path
  //////////////////////////////////////////////////
  cmd_assembler u_cmd_assembler (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_req         (spi_req.requester)
  );

  spi_master u_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_req         (spi_req.shifter),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_mosi_o      (spi_mosi_o),
    .spi_miso_i      (spi_miso_i)
  );

  reply_queue u_reply_queue (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_req         (spi_req.collector),
    .tx_active_i     (tx_active),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  //////////////////////////////////////////////////
  // display control pins
  //////////////////////////////////////////////////
  slm_reset_gen u_slm_reset_gen (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  // display runs straight off the system clock
  assign slm_clk_o = fpga_clk;

endmodule

// File: hdl/slm_reset_gen.sv
// display reset stretcher
// active low reset follows the command and stays low
// for a fixed number of cycles once it is released
`timescale 1ns/1ps
`include "slm_cfg.svh"

module slm_reset_gen (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);

  localparam int HOLD_W = $clog2(`SLM_RESET_HOLD + 1);

  logic [HOLD_W-1:0] hold_cnt;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // reload for as long as the command is up
      hold_cnt      <= HOLD_W'(`SLM_RESET_HOLD);
      slm_reset_n_o <= 1'b0;
    end else if (hold_cnt != '0) begin
      hold_cnt      <= hold_cnt - 1'b1;
      slm_reset_n_o <= 1'b0;
    end else begin
      slm_reset_n_o <= 1'b1;
    end
  end

endmodule

// File: hdl/spi_master.sv
// display spi master
// 16 bit mode 0 write, msb first, mosi moves on sck fall
// miso sampled on sck rise, last eight bits kept as the reply
`timescale 1ns/1ps
`include "slm_cfg.svh"

// request from assembler, reply toward the queue
interface spi_req_if import spi_pkg::*, uart_pkg::*; ();
  logic       start;
  spi_frame_u frame;
  logic       done;
  uart_byte_t reply;

  modport requester (output start, output frame);
  modport shifter (input start, input frame, output done, output reply);
  modport collector (input done, input reply);
endinterface

module spi_master import spi_pkg::*, uart_pkg::*; (
  input  logic      fpga_clk,
  input  logic      reset_all_cmd_w,
  spi_req_if.shifter spi_req,
  output logic      spi_sen_o,
  output logic      spi_sck_o,
  output logic      spi_mosi_o,
  input  logic      spi_miso_i
);

  localparam int HALF = `SLM_SPI_HALF_PERIOD;
  localparam int DIV_W = $clog2(HALF + 1);
  localparam int BIT_W = $clog2(SPI_FRAME_BITS);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(HALF - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(SPI_FRAME_BITS - 1);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_SHIFT = 2'd1;
  localparam logic [1:0] S_TAIL = 2'd2;
  localparam logic [1:0] S_DONE = 2'd3;

  logic [1:0]                state;
  logic [DIV_W-1:0]          div_cnt;
  logic [BIT_W-1:0]          bit_cnt;
  logic [SPI_FRAME_BITS-1:0] tx_sh;
  uart_byte_t                rx_sh;

  assign spi_mosi_o = tx_sh[SPI_FRAME_BITS-1];

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state        <= S_IDLE;
      div_cnt      <= '0;
      bit_cnt      <= '0;
      tx_sh        <= '0;
      spi_sen_o    <= 1'b1;
      spi_sck_o    <= 1'b0;
      spi_req.done <= 1'b0;
    end else begin
      spi_req.done <= 1'b0;
      case (state)
        S_IDLE: begin
          // first bit is on mosi as sen drops
          if (spi_req.start) begin
            tx_sh     <= spi_req.frame.raw;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            spi_sen_o <= 1'b0;
            state     <= S_SHIFT;
          end
        end
        S_SHIFT: begin
          if (div_cnt == DIV_LAST) begin
            div_cnt <= '0;
            if (!spi_sck_o) begin
              // rising edge
              spi_sck_o <= 1'b1;
              rx_sh     <= {rx_sh[UART_DATA_BITS-2:0], spi_miso_i};
            end else begin
              // falling edge
              spi_sck_o <= 1'b0;
              if (bit_cnt == BIT_LAST) begin
                state <= S_TAIL;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
                tx_sh   <= {tx_sh[SPI_FRAME_BITS-2:0], 1'b0};
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        S_TAIL: begin
          // half period hold before sen release
          if (div_cnt == DIV_LAST) begin
            div_cnt   <= '0;
            spi_sen_o <= 1'b1;
            state     <= S_DONE;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          spi_req.done  <= 1'b1;
          spi_req.reply <= rx_sh;
          state         <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// File: hdl/spi_pkg.sv
// display spi frame types
// one 16 bit write is an address byte followed by a data byte,
// address goes out first
package spi_pkg;

  // bits per spi write
  localparam int SPI_FRAME_BITS = 16;

  // display register address
  typedef logic [7:0] spi_reg_addr_t;

  // raw word for the shifter
  // addr/data view for the assembler
  typedef union packed {
    logic [SPI_FRAME_BITS-1:0] raw;
    struct packed {
      spi_reg_addr_t addr;
      logic [7:0]    data;
    } field;
  } spi_frame_u;

endpackage

// File: hdl/uart_pkg.sv
// host uart side types
// byte type shared by receiver, transmitter, reply queue
// and command assembler
package uart_pkg;

  // data bits per uart character
  localparam int UART_DATA_BITS = 8;

  // one received or transmitted character
  typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

endpackage

// File: hdl/uart_rx.sv
// uart receiver
// two flop synchronizer, samples each bit at mid period
// strobes valid for one cycle when a byte ends with a good stop bit
`timescale 1ns/1ps
`include "slm_cfg.svh"

module uart_rx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = `SLM_CLKS_PER_BIT
) (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       rx_serial_i,
  output logic       rx_valid_o,
  output uart_byte_t rx_byte_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_MID = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [2:0] BIT_LAST = 3'(UART_DATA_BITS - 1);

  // fsm encodings
  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA = 2'd2;
  localparam logic [1:0] S_STOP = 2'd3;

  logic             rx_meta;
  logic             rx_sync;
  logic [1:0]       state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  uart_byte_t       shift_q;

  // line idles high
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_serial_i;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state      <= S_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // falling edge marks a start bit
          if (!rx_sync) begin
            state <= S_START;
          end
        end
        S_START: begin
          if (clk_cnt == CNT_MID) begin
            clk_cnt <= '0;
            // still low at mid bit, otherwise a glitch
            state <= rx_sync ? S_IDLE : S_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (clk_cnt == CNT_LAST) begin
            clk_cnt <= '0;
            // lsb first
            shift_q <= {rx_sync, shift_q[UART_DATA_BITS-1:1]};
            if (bit_idx == BIT_LAST) begin
              state <= S_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          // mid stop bit, drop the byte on a framing error
          if (clk_cnt == CNT_LAST) begin
            state <= S_IDLE;
            if (rx_sync) begin
              rx_valid_o <= 1'b1;
              rx_byte_o  <= shift_q;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

// File: hdl/uart_tx.sv
// uart transmitter
// start bit, eight data bits lsb first, one stop bit
// active stays high from the cycle after start to the end of stop
`timescale 1ns/1ps
`include "slm_cfg.svh"

module uart_tx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = `SLM_CLKS_PER_BIT
) (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       tx_start_i,
  input  uart_byte_t tx_byte_i,
  output logic       tx_active_o,
  output logic       tx_serial_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [2:0] BIT_LAST = 3'(UART_DATA_BITS - 1);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA = 2'd2;
  localparam logic [1:0] S_STOP = 2'd3;

  logic [1:0]       state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  uart_byte_t       shift_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state       <= S_IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      tx_active_o <= 1'b0;
      tx_serial_o <= 1'b1;
    end else begin
      case (state)
        S_IDLE: begin
          // start bit goes out with active
          if (tx_start_i) begin
            shift_q     <= tx_byte_i;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            tx_active_o <= 1'b1;
            tx_serial_o <= 1'b0;
            state       <= S_START;
          end
        end
        S_START: begin
          if (clk_cnt == CNT_LAST) begin
            clk_cnt     <= '0;
            tx_serial_o <= shift_q[0];
            state       <= S_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (clk_cnt == CNT_LAST) begin
            clk_cnt <= '0;
            if (bit_idx == BIT_LAST) begin
              tx_serial_o <= 1'b1;
              state       <= S_STOP;
            end else begin
              bit_idx     <= bit_idx + 1'b1;
              shift_q     <= shift_q >> 1;
              tx_serial_o <= shift_q[1];
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          // full stop bit then release
          if (clk_cnt == CNT_LAST) begin
            tx_active_o <= 1'b0;
            state       <= S_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the display command path testbench with verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_slm_ctrl -Mdir obj_dir -f sources.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit $build_status
fi

./obj_dir/Vtb_slm_ctrl
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit $sim_status
fi

echo "simulation passed"
exit 0

// File: sources.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/spi_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/spi_master.sv
hdl/cmd_assembler.sv
hdl/reply_queue.sv
hdl/slm_reset_gen.sv
hdl/slm_ctrl_top.sv
bench/spi_slave_model.sv
bench/tb_slm_ctrl.sv
